// File: flist.f
verilog/synth_ctrl_pkg.sv
verilog/audio_pkg.sv
verilog/key_control.sv
verilog/voice_dds.sv
verilog/voice_mixer.sv
verilog/echo_pwm_out.sv
verilog/poly_synth.sv
tests/key_control_checker.sv
tests/poly_synth_tb.sv

// File: Makefile
# Verilator build and run of the synth core testbench, from the project root
TOP = poly_synth_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f flist.f --Mdir obj_dir -o sim
	@out="$$(./obj_dir/sim 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// File: verilog/freq_table.mem
// Base frequency in Hz (hex) per scan code; row n holds codes n0..nF; 000 = not a note
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 07B 06E 000 000 000
000 000 000 083 000 000 000 000 000 000 000 093 000 000 000 000
000 000 000 0AF 0A5 000 000 000 000 000 000 0C4 000 000 000 000
000 000 0DC 000 000 000 000 000 000 000 000 0F7 106 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000 000 000 000 000 000 000 000 000

// File: verilog/sine_lut.mem
// One sine period, 32 unsigned 10-bit samples in hex, midscale 200 at entry 0
200
264
2C4
31C
369
3A9
3D8
3F5
3FF
3F5
3D8
3A9
369
31C
2C4
264
200
19C
13C
0E4
097
057
028
00B
001
00B
028
057
097
0E4
13C
19C

// File: tests/poly_synth_tb.sv
// Run from the project root so both .mem paths resolve; zero-Hz notes give a steady PWM duty
`timescale 1ns/1ps

module poly_synth_tb;
    import synth_ctrl_pkg::*;
    import audio_pkg::*;

    // ====================
    // Run length
    // ====================
    localparam time CLK_PERIOD   = 100ns;
    localparam int  RESET_CYCLES = 10;
    localparam int  RAND_OPS     = 200;            // Random makes and breaks, 2 cycles max
    localparam int  MEAS_CYCLES  = 2**PWM_BITS;    // One PWM period
    localparam int  SETTLE       = 8;              // Mixer and echo pipeline
    localparam int  TOTAL_CYCLES = 3 * RESET_CYCLES + 2 * RAND_OPS + 200
                                 + 4 * (SETTLE + MEAS_CYCLES) + 3 * DELAY_DEPTH;

    logic          modclk;
    logic          reset;
    scan_code_e    key_byte;
    logic          key_valid;
    synth_status_t status;
    logic          audio_out;

    logic [FREQ_BITS-1:0]  freq_ref [256];              // Own copies of the tables
    sample_t               sine_ref [2**LUT_ADDR_BITS];
    tone_ctrl_t            m_tone;                      // Model of the tone settings
    logic [NUM_VOICES-1:0] m_active;
    logic [7:0]            m_code [NUM_VOICES];
    logic                  m_break;                     // F0 seen
    logic [7:0]            pool [12] = '{8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h34, 8'h33,
                                         8'h3B, 8'h42, 8'h4B, 8'h4C, 8'h15, 8'h1D};
    integer                seed;
    string                 test_name;
    logic [31:0]           r;
    sample_t               duty;

    poly_synth dut (
        .modclk    (modclk),
        .reset     (reset),
        .key_byte  (key_byte),
        .key_valid (key_valid),
        .status    (status),
        .audio_out (audio_out)
    );

    bind key_control key_control_checker u_checker (
        .modclk    (modclk),
        .reset     (reset),
        .key_valid (key_valid),
        .voices    (voices),
        .tone      (tone),
        .status    (status)
    );

    initial begin
        modclk = 1'b0;
        forever #(CLK_PERIOD / 2) modclk = ~modclk;
    end

    initial begin
        #(TOTAL_CYCLES * 2 * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES * 2);
        $display("Something failed");
        $fatal(1);
    end

    // ====================
    // Reference model
    // ====================
    task automatic model_byte(input logic [7:0] b);
        int   oct;
        int   pit;
        int   slot;
        logic held;
        oct  = m_tone.octave;
        pit  = m_tone.pitch_mod;
        slot = -1;
        held = 1'b0;
        if (b == BREAK_PREFIX) begin
            m_break = 1'b1;
        end else if (m_break) begin
            m_break = 1'b0;
            foreach (m_code[i]) begin
                if (m_code[i] == b)
                    m_active[i] = 1'b0;   // Every slot with this key
            end
        end else begin
            case (b)
                Z_KEY: oct = (oct - 1 < OCTAVE_MIN) ? OCTAVE_MIN : oct - 1;
                X_KEY: oct = (oct + 1 > OCTAVE_MAX) ? OCTAVE_MAX : oct + 1;
                C_KEY: m_tone.delay_on = !m_tone.delay_on;
                V_KEY: pit = (pit - PITCH_STEP < -PITCH_MAX) ? -PITCH_MAX : pit - PITCH_STEP;
                B_KEY: pit = (pit + PITCH_STEP > PITCH_MAX) ? PITCH_MAX : pit + PITCH_STEP;
                default: begin
                    foreach (m_code[i]) begin
                        if (m_active[i] && m_code[i] == b)
                            held = 1'b1;
                    end
                    for (int i = 0; i < NUM_VOICES && slot < 0; i++) begin
                        if (!m_active[i])
                            slot = i;   // Lowest free
                    end
                    if (freq_ref[b] != 0 && !held && slot >= 0) begin
                        m_active[slot] = 1'b1;
                        m_code[slot]   = b;
                    end
                end
            endcase
            m_tone.octave    = octave_t'(oct);
            m_tone.pitch_mod = pitch_t'(pit);
        end
    endtask

    function automatic synth_status_t expected_status();
        synth_status_t s;
        s.octave       = m_tone.octave;
        s.pitch_mod    = m_tone.pitch_mod;
        s.delay_on     = m_tone.delay_on;
        s.voice_active = m_active;
        return s;
    endfunction

    // Phase stuck at zero, so each voice adds sine entry 0, then the mix is divided by four
    function automatic sample_t expected_duty(input int voices_on, input bit echo);
        int s;
        s = voices_on * sine_ref[0] / 4;
        if (s > 2**PWM_BITS - 1)
            s = 2**PWM_BITS - 1;
        if (echo)
            s = (s + s) / 2;   // Delayed copy equals the live sample
        return sample_t'(s);
    endfunction

    // ====================
    // Compare tasks
    // ====================
    task automatic compare_status(input string name, input synth_status_t expected,
                                  input synth_status_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %05h, actual %05h", name, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic compare_duty(input string name, input sample_t expected,
                                input sample_t actual);
        if (actual !== expected) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // ====================
    // Stimulus
    // ====================
    task automatic apply_reset();
        reset     = 1'b1;
        key_valid = 1'b0;
        repeat (RESET_CYCLES) @(negedge modclk);
        reset    = 1'b0;
        m_tone   = '0;
        m_active = '0;
        m_break  = 1'b0;
        foreach (m_code[i])
            m_code[i] = '0;
    endtask

    // Called on a falling edge, one byte for one cycle, status checked after
    task automatic send_key(input logic [7:0] b);
        key_byte  = scan_code_e'(b);
        key_valid = 1'b1;
        @(negedge modclk);
        key_valid = 1'b0;
        model_byte(b);
        compare_status(test_name, expected_status(), status);
    endtask

    task automatic release_key(input logic [7:0] b);
        send_key(BREAK_PREFIX);
        send_key(b);
    endtask

    // Octave down plus full negative offset takes notes under 202 Hz to 0 Hz
    task automatic zero_pitch();
        send_key(Z_KEY);
        repeat (PITCH_MAX / PITCH_STEP) send_key(V_KEY);
    endtask

    task automatic measure_duty(output sample_t high_cycles);
        int highs;
        highs = 0;
        repeat (SETTLE) @(negedge modclk);
        repeat (MEAS_CYCLES) begin
            @(negedge modclk);
            if (audio_out)
                highs++;
        end
        high_cycles = sample_t'(highs);
    endtask

    initial begin
        seed      = 32'h8a384310;
        key_byte  = scan_code_e'(8'h00);
        key_valid = 1'b0;
        reset     = 1'b1;
        $readmemh("verilog/freq_table.mem", freq_ref);
        $readmemh("verilog/sine_lut.mem", sine_ref);
        apply_reset();

        test_name = "voice allocation";
        for (int n = 0; n < RAND_OPS; n++) begin
            r = $random(seed);
            if (r[11:8] < 4'd10)
                send_key(pool[r[7:0] % 12]);      // Make, mostly
            else
                release_key(pool[r[7:0] % 12]);
        end

        test_name = "octave and pitch clamping";
        repeat (5) send_key(X_KEY);
        repeat (8) send_key(Z_KEY);
        repeat (30) send_key(V_KEY);
        repeat (55) send_key(B_KEY);

        test_name = "echo toggle";
        repeat (4) send_key(C_KEY);

        apply_reset();
        test_name = "pwm duty";
        zero_pitch();
        send_key(8'h1C);
        measure_duty(duty);
        compare_duty(test_name, expected_duty(1, 1'b0), duty);
        send_key(8'h1B);
        measure_duty(duty);
        compare_duty(test_name, expected_duty(2, 1'b0), duty);
        release_key(8'h1C);
        release_key(8'h1B);
        measure_duty(duty);
        compare_duty(test_name, expected_duty(0, 1'b0), duty);

        apply_reset();
        test_name = "echo with constant input";
        repeat (DELAY_DEPTH) @(negedge modclk);   // Delay line filled with zeros
        send_key(C_KEY);
        zero_pitch();
        send_key(8'h1C);
        repeat (2 * DELAY_DEPTH) @(negedge modclk);
        measure_duty(duty);
        compare_duty(test_name, expected_duty(1, 1'b1), duty);

        $display("Everything OK");
        $finish;
    end

endmodule

// File: tests/key_control_checker.sv
// Bound to key_control; assumes key_valid stays low while reset is high
`timescale 1ns/1ps

module key_control_checker (
    input logic                          modclk,
    input logic                          reset,
    input logic                          key_valid,
    input synth_ctrl_pkg::voice_bank_t   voices,
    input synth_ctrl_pkg::tone_ctrl_t    tone,
    input synth_ctrl_pkg::synth_status_t status
);
    import synth_ctrl_pkg::*;

    logic dup_code;   // Two live slots share one key

    always_comb begin
        dup_code = 1'b0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            for (int j = i + 1; j < NUM_VOICES; j++) begin
                if (voices[i].active && voices[j].active && voices[i].code == voices[j].code)
                    dup_code = 1'b1;
            end
        end
    end

    // ====================
    // Properties
    // ====================
    status_follows_byte: assert property (@(posedge modclk) disable iff (reset)
        $changed(status) |-> $past(key_valid))          // Only a byte moves status
        else $error("status changed on a cycle with no key byte before it");

    tone_in_range: assert property (@(posedge modclk) disable iff (reset)
        tone.octave >= OCTAVE_MIN && tone.octave <= OCTAVE_MAX &&
        tone.pitch_mod >= -PITCH_MAX && tone.pitch_mod <= PITCH_MAX)
        else $error("octave or pitch offset left its clamp range");

    codes_unique: assert property (@(posedge modclk) disable iff (reset) !dup_code)
        else $error("two active voices hold the same scan code");

endmodule

// File: verilog/poly_synth.sv
// Top of the synth core; key bytes come pre-decoded and nothing ever stalls
`timescale 1ns/1ps

module poly_synth (
    input  logic                          modclk,
    input  logic                          reset,
    input  synth_ctrl_pkg::scan_code_e    key_byte,
    input  logic                          key_valid,
    output synth_ctrl_pkg::synth_status_t status,
    output logic                          audio_out
);
    import synth_ctrl_pkg::*;
    import audio_pkg::*;

    voice_bank_t voices;   // Registered voice slots
    tone_ctrl_t  tone;     // Octave, pitch, echo
    phase_bank_t phases;
    sample_t     mix;      // One cycle behind phases

    key_control u_key_control (
        .modclk    (modclk),
        .reset     (reset),
        .key_byte  (key_byte),
        .key_valid (key_valid),
        .voices    (voices),
        .tone      (tone),
        .status    (status)
    );

    voice_dds u_voice_dds (
        .modclk (modclk),
        .reset  (reset),
        .voices (voices),
        .tone   (tone),
        .phases (phases)
    );

    // Active bits ride along inside voices
    voice_mixer u_voice_mixer (
        .modclk (modclk),
        .reset  (reset),
        .voices (voices),
        .phases (phases),
        .mix    (mix)
    );

    echo_pwm_out u_echo_pwm_out (
        .modclk    (modclk),
        .reset     (reset),
        .mix       (mix),
        .delay_on  (tone.delay_on),
        .audio_out (audio_out)
    );

endmodule

// File: verilog/echo_pwm_out.sv
// Echo is a single tap DELAY_DEPTH cycles back; delay memory holds garbage until filled after reset
`timescale 1ns/1ps

module echo_pwm_out (
    input  logic               modclk,
    input  logic               reset,
    input  audio_pkg::sample_t mix,
    input  logic               delay_on,
    output logic               audio_out   // PWM pin
);
    import audio_pkg::*;

    sample_t                        delay_buf [DELAY_DEPTH];
    logic [$clog2(DELAY_DEPTH)-1:0] delay_ptr;   // Wraps naturally
    sample_t                        delayed;     // Mix from DELAY_DEPTH cycles ago
    logic [PWM_BITS:0]              echo_sum;    // Carry kept for the average
    sample_t                        out_sample;
    logic [PWM_BITS-1:0]            pwm_cnt;

    // ====================
    // Delay line
    // ====================
    always_ff @(posedge modclk) begin
        delay_buf[delay_ptr] <= mix;   // Overwrites the oldest entry
    end

    always_ff @(posedge modclk or posedge reset) begin
        if (reset)
            delay_ptr <= '0;
        else
            delay_ptr <= delay_ptr + 1'b1;
    end

    assign delayed  = delay_buf[delay_ptr];        // Read before this edge's write
    assign echo_sum = {1'b0, mix} + {1'b0, delayed};

    // Half dry, half delayed
    assign out_sample = delay_on ? echo_sum[PWM_BITS:1] : mix;

    // ====================
    // PWM
    // ====================
    always_ff @(posedge modclk or posedge reset) begin
        if (reset)
            pwm_cnt <= '0;
        else
            pwm_cnt <= pwm_cnt + 1'b1;   // Free running, period 2^PWM_BITS
    end

    // S high cycles per period for a steady sample S
    assign audio_out = (pwm_cnt < out_sample);

endmodule

// File: verilog/voice_mixer.sv
// Sum saturates above four full-scale voices; reads verilog/sine_lut.mem from the run dir
`timescale 1ns/1ps

module voice_mixer (
    input  logic                        modclk,
    input  logic                        reset,
    input  synth_ctrl_pkg::voice_bank_t voices,
    input  audio_pkg::phase_bank_t      phases,
    output audio_pkg::sample_t          mix
);
    import synth_ctrl_pkg::*;
    import audio_pkg::*;

    // Wide enough for every voice at full scale
    typedef logic [PWM_BITS+$clog2(NUM_VOICES)-1:0] sum_t;

    sample_t sine_lut [2**LUT_ADDR_BITS];  // One period, entry 0 at midscale
    sum_t    sine_sum;

    initial $readmemh("verilog/sine_lut.mem", sine_lut);

    // Top phase bits address the table
    always_comb begin
        sine_sum = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (voices[i].active)
                sine_sum = sine_sum + sum_t'(sine_lut[phases[i][PHASE_BITS-1 -: LUT_ADDR_BITS]]);
        end
    end

    // Registered divide by four, breaks the long adder path
    always_ff @(posedge modclk or posedge reset) begin
        if (reset)
            mix <= '0;
        else if ((sine_sum >> 2) > sum_t'(2**PWM_BITS - 1))
            mix <= '1;                         // Clip
        else
            mix <= sine_sum[PWM_BITS+1:2];
    end

endmodule

// File: verilog/voice_dds.sv
// Frequencies are whole Hz and clamp at zero; phase restarts from zero whenever a voice is idle
`timescale 1ns/1ps

module voice_dds (
    input  logic                        modclk,
    input  logic                        reset,
    input  synth_ctrl_pkg::voice_bank_t voices,
    input  synth_ctrl_pkg::tone_ctrl_t  tone,
    output audio_pkg::phase_bank_t      phases
);
    import synth_ctrl_pkg::*;
    import audio_pkg::*;

    // Base << 3 plus 100 Hz still fits in 16 bits
    typedef logic [FREQ_BITS+3:0] play_freq_t;

    phase_t phase_inc [NUM_VOICES];  // Per-voice step, combinational

    // ====================
    // Transposition and offset
    // ====================
    function automatic play_freq_t voice_freq(input voice_t v, input tone_ctrl_t t);
        play_freq_t                  shifted;
        logic signed [FREQ_BITS+4:0] offset;   // One spare bit for the sign
        if (t.octave > 0)
            shifted = play_freq_t'(v.base_freq) << t.octave;        // Up
        else if (t.octave < 0)
            shifted = play_freq_t'(v.base_freq) >> 3'(-t.octave);   // Down
        else
            shifted = play_freq_t'(v.base_freq);
        offset = $signed({1'b0, shifted}) + t.pitch_mod;  // Sign-extends the offset
        // Negative frequency means silence, not a wrap
        if (offset < 0)
            return '0;
        return offset[FREQ_BITS+3:0];
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_VOICES; i++) begin
            // Hz times counts per Hz
            phase_inc[i] = phase_t'(voice_freq(voices[i], tone)) * PHASE_INC_MULT;
        end
    end

    // ====================
    // Accumulators
    // ====================
    always_ff @(posedge modclk or posedge reset) begin
        if (reset) begin
            phases <= '0;
        end else begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                if (voices[i].active)
                    phases[i] <= phases[i] + phase_inc[i];  // Wraps once per period
                else
                    phases[i] <= '0;                        // Note starts at phase 0
            end
        end
    end

endmodule

// File: verilog/key_control.sv
// Bytes must arrive decoded with a one-cycle strobe; reads verilog/freq_table.mem from the run dir
`timescale 1ns/1ps

module key_control (
    input  logic                          modclk,
    input  logic                          reset,
    input  synth_ctrl_pkg::scan_code_e    key_byte,
    input  logic                          key_valid,   // One cycle per byte
    output synth_ctrl_pkg::voice_bank_t   voices,
    output synth_ctrl_pkg::tone_ctrl_t    tone,
    output synth_ctrl_pkg::synth_status_t status
);
    import synth_ctrl_pkg::*;

    typedef enum logic {
        IDLE,   // Next byte is a make code
        BREAK   // F0 seen, next byte is released
    } key_state_e;

    key_state_e           state;
    logic [FREQ_BITS-1:0] freq_table [256];  // Zero means not a note
    logic [FREQ_BITS-1:0] key_freq;          // Table entry of this byte
    logic                 held;              // Code already sounding
    int                   free_slot;         // NUM_VOICES when the bank is full

    initial $readmemh("verilog/freq_table.mem", freq_table);

    assign key_freq = freq_table[key_byte];

    // ====================
    // Slot search
    // ====================
    always_comb begin
        held      = 1'b0;
        free_slot = NUM_VOICES;
        // Walk downward so the lowest free slot wins
        for (int i = NUM_VOICES - 1; i >= 0; i--) begin
            if (voices[i].active && voices[i].code == key_byte)
                held = 1'b1;
            if (!voices[i].active)
                free_slot = i;
        end
    end

    // ====================
    // Byte handling
    // ====================
    always_ff @(posedge modclk or posedge reset) begin
        if (reset) begin
            state  <= IDLE;
            voices <= '0;
            tone   <= '0;
        end else if (key_valid) begin
            if (key_byte == BREAK_PREFIX) begin
                state <= BREAK;                       // Arm release
            end else if (state == BREAK) begin
                state <= IDLE;
                for (int i = 0; i < NUM_VOICES; i++) begin
                    if (voices[i].code == key_byte)
                        voices[i].active <= 1'b0;     // Free every match
                end
            end else begin
                case (key_byte)
                    Z_KEY: if (tone.octave > OCTAVE_MIN)
                        tone.octave <= tone.octave - 3'sd1;
                    X_KEY: if (tone.octave < OCTAVE_MAX)
                        tone.octave <= tone.octave + 3'sd1;
                    C_KEY: tone.delay_on <= ~tone.delay_on;
                    V_KEY: if (tone.pitch_mod > -PITCH_MAX)
                        tone.pitch_mod <= tone.pitch_mod - pitch_t'(PITCH_STEP);
                    B_KEY: if (tone.pitch_mod < PITCH_MAX)
                        tone.pitch_mod <= tone.pitch_mod + pitch_t'(PITCH_STEP);
                    default: begin
                        // Musical key: new note into the lowest free slot
                        if (key_freq != '0 && !held && free_slot < NUM_VOICES) begin
                            voices[free_slot].active    <= 1'b1;
                            voices[free_slot].code      <= key_byte;
                            voices[free_slot].base_freq <= key_freq;
                        end
                        // Full bank drops the key silently
                    end
                endcase
            end
        end
    end

    // Status straight from the registers
    always_comb begin
        status.octave    = tone.octave;
        status.pitch_mod = tone.pitch_mod;
        status.delay_on  = tone.delay_on;
        for (int i = 0; i < NUM_VOICES; i++)
            status.voice_active[i] = voices[i].active;
    end

endmodule

// File: verilog/audio_pkg.sv
// Audio path widths; PHASE_INC_MULT assumes a 100 MHz modclk and 32-bit phase
package audio_pkg;

    // ====================
    // DDS and output widths
    // ====================
    localparam int PHASE_BITS    = 32;
    localparam int LUT_ADDR_BITS = 5;     // 32-entry sine table
    localparam int PWM_BITS      = 10;    // Sample and PWM counter width

    // 2^32 / 100e6 is about 42.9 counts per Hz
    localparam int unsigned PHASE_INC_MULT = 42;

    // Echo length in modclk cycles, power of two
    localparam int DELAY_DEPTH = 1024;

    typedef logic [PHASE_BITS-1:0] phase_t;
    typedef logic [PWM_BITS-1:0]   sample_t;  // Unsigned, midscale is 512

    // One accumulator per voice
    typedef phase_t [synth_ctrl_pkg::NUM_VOICES-1:0] phase_bank_t;

endpackage

// File: verilog/synth_ctrl_pkg.sv
// Control types for set-2 make/break bytes only; extended E0 codes are not decoded
package synth_ctrl_pkg;

    // ====================
    // Limits
    // ====================
    localparam int NUM_VOICES = 8;    // Polyphony
    localparam int FREQ_BITS  = 12;   // Base frequency in whole Hz
    localparam int OCTAVE_MIN = -3;
    localparam int OCTAVE_MAX = 3;
    localparam int PITCH_MAX  = 100;  // Hz either way
    localparam int PITCH_STEP = 4;    // Hz per V or B press

    // Control make codes plus the break prefix
    typedef enum logic [7:0] {
        Z_KEY        = 8'h1A,  // Octave down
        X_KEY        = 8'h22,  // Octave up
        C_KEY        = 8'h21,  // Echo toggle
        V_KEY        = 8'h2A,  // Pitch down
        B_KEY        = 8'h32,  // Pitch up
        BREAK_PREFIX = 8'hF0   // Next byte is a release
    } scan_code_e;

    typedef logic signed [2:0] octave_t;
    typedef logic signed [7:0] pitch_t;

    // One voice slot, 21 bits
    typedef struct packed {
        logic                 active;
        logic [7:0]           code;       // Scan code holding the slot
        logic [FREQ_BITS-1:0] base_freq;  // Untransposed note frequency
    } voice_t;

    typedef voice_t [NUM_VOICES-1:0] voice_bank_t;

    // Tone settings shared by all voices, 12 bits
    typedef struct packed {
        octave_t octave;
        pitch_t  pitch_mod;
        logic    delay_on;
    } tone_ctrl_t;

    // Status word seen outside, 20 bits
    typedef struct packed {
        octave_t                 octave;
        pitch_t                  pitch_mod;
        logic                    delay_on;
        logic [NUM_VOICES-1:0]   voice_active;
    } synth_status_t;

endpackage
